// ==== compile.f ====
+incdir+src
src/spi_capture_pkg.sv
src/spi_frame_engine.sv
src/frame_scheduler.sv
src/capture_fifo.sv
src/result_reader.sv
src/spi_capture_top.sv
dv/spi_capture_asserts.sv
dv/tb_clkgen.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== dv/spi_capture_asserts.sv ====
`default_nettype none
`include "spi_capture_params.svh"

module spi_capture_asserts (
    input wire clk,
    input wire rst,
    input wire cs,
    input wire sclk,
    input wire mosi,
    input wire fd_prd
);

    timeunit 1ns;
    timeprecision 100ps;

    // Four cycles per bit plus the tail.
    localparam int CS_LOW_CYCLES = `SPI_WORD_W * 4 + 4;

    int low_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            low_cnt <= 0;
        end else if (cs) begin
            low_cnt <= 0;
        end else begin
            low_cnt <= low_cnt + 1;
        end
    end

    cs_whole_frame: assert property (@(posedge clk) disable iff (rst)
        $rose(cs) |-> (low_cnt == CS_LOW_CYCLES))
        else $error("cs rose after %0d low cycles", low_cnt);

    sclk_idle_low: assert property (@(posedge clk) disable iff (rst) cs |-> !sclk)
        else $error("sclk high while cs is high");

    done_outside_frame: assert property (@(posedge clk) disable iff (rst) fd_prd |-> cs)
        else $error("fd_prd high while cs is low");

    mosi_hold: assert property (@(posedge clk) disable iff (rst) sclk |-> $stable(mosi))
        else $error("mosi changed while sclk is high");

endmodule

bind spi_frame_engine spi_capture_asserts u_asserts (
    .clk    (clk),
    .rst    (rst),
    .cs     (cs),
    .sclk   (sclk),
    .mosi   (mosi),
    .fd_prd (fd_prd)
);

`default_nettype wire

// ==== dv/tb_checker.sv ====
`default_nettype none
`include "spi_capture_params.svh"

module tb_checker (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   cs,
    input  wire                   busy,
    input  wire                   rd_valid,
    input  wire                   is_reg,
    input  wire [6:0]             reg_addr,
    input  wire [7:0]             reg_data,
    input  wire [3:0]             sample_chan,
    input  wire [11:0]            sample_value,
    input  wire [`SPI_WORD_W-1:0] rx_late,
    input  wire [`SPI_WORD_W-1:0] mosi_word,
    input  wire                   exp_valid,
    input  wire [`SPI_WORD_W-1:0] exp_tx,
    input  wire [47:0]            exp_res,
    input  wire                   test_end,
    input  wire [7:0]             test_num,
    input  wire                   all_done,
    output int                    error_count
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [`SPI_WORD_W-1:0] tx_q [$];
    logic [47:0]            res_q [$];                // {is_reg, addr, data, chan, value, late}.
    logic [47:0]            held;
    logic [47:0]            now_out;
    logic                   cs_prev;
    logic                   seen_valid;
    int                     checks;
    int                     check_base;
    int                     error_base;
    int                     tests_run;
    int                     tests_failed;

    assign now_out = {is_reg, reg_addr, reg_data, sample_chan, sample_value, rx_late};

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    always @(posedge clk) begin
        logic [47:0] expv;
        if (rst) begin
            tx_q.delete();
            res_q.delete();
            held         = '0;
            cs_prev      = 1'b1;
            seen_valid   = 1'b0;
            checks       = 0;
            check_base   = 0;
            error_base   = 0;
            tests_run    = 0;
            tests_failed = 0;
            error_count  = 0;
        end else begin
            // A frame in flight or a full FIFO holds busy.
            if (tx_q.size() != 0 || (res_q.size() >= `CAP_FIFO_DEPTH && !rd_valid)) begin
                check_value("busy", 16'(busy), 16'h1);
            end
            if (exp_valid) begin
                tx_q.push_back(exp_tx);
                res_q.push_back(exp_res);
            end
            // ################################################################
            // Frame on the wire
            // ################################################################
            if (cs && !cs_prev) begin
                if (tx_q.size() == 0) begin
                    error_count++;
                    $display("A frame ran on the bus although no command was accepted");
                end else begin
                    check_value("mosi", mosi_word, tx_q.pop_front());
                end
            end
            // ################################################################
            // Reader outputs
            // ################################################################
            if (rd_valid) begin
                if (res_q.size() == 0) begin
                    error_count++;
                    $display("rd_valid pulsed with no captured result outstanding");
                end else begin
                    expv = res_q.pop_front();
                    check_value("is_reg", 16'(is_reg), 16'(expv[47]));
                    if (expv[47]) begin
                        check_value("reg_addr", 16'(reg_addr), 16'(expv[46:40]));
                        check_value("reg_data", 16'(reg_data), 16'(expv[39:32]));
                    end else begin
                        check_value("sample_chan", 16'(sample_chan), 16'(expv[31:28]));
                        check_value("sample_value", 16'(sample_value), 16'(expv[27:16]));
                    end
                    check_value("rx_late", rx_late, expv[15:0]);
                end
                seen_valid = 1'b1;
            end else if (seen_valid && now_out !== held) begin
                error_count++;
                $display("CHECK FAILED reader outputs: got 0x%h, held 0x%h", now_out, held);
            end
            held    = now_out;
            cs_prev = cs;
            if (test_end) begin
                tests_run++;
                if (error_count == error_base) begin
                    $display("test %0d done: %0d checks, no errors", test_num,
                             checks - check_base);
                end else begin
                    tests_failed++;
                    $display("test %0d done: %0d checks, %0d errors", test_num,
                             checks - check_base, error_count - error_base);
                end
                check_base = checks;
                error_base = error_count;
            end
            if (all_done) begin
                if (tx_q.size() != 0 || res_q.size() != 0) begin
                    error_count++;
                    $display("%0d frames and %0d results never showed up",
                             tx_q.size(), res_q.size());
                end
                $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                         tests_run, tests_failed, checks, error_count);
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_clkgen.sv ====
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                       // 10 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== dv/tb_top.sv ====
`default_nettype none
`include "spi_capture_params.svh"

module tb_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CMD_BUDGET      = 20;
    localparam int CYCLES_PER_CMD  = 120;
    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES = CMD_BUDGET * CYCLES_PER_CMD + RESET_CYCLES;

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic [`SPI_WORD_W-1:0] tx_word;
    logic                   busy;
    logic                   miso;
    logic                   sclk;
    logic                   mosi;
    logic                   cs;
    logic                   rd;
    logic                   rd_valid;
    logic                   is_reg;
    logic [6:0]             reg_addr;
    logic [7:0]             reg_data;
    logic [3:0]             sample_chan;
    logic [11:0]            sample_value;
    logic [`SPI_WORD_W-1:0] rx_late;

    logic                   exp_valid;
    logic [`SPI_WORD_W-1:0] exp_tx;
    logic [47:0]            exp_res;
    logic                   test_end;
    logic [7:0]             test_num;
    logic                   all_done;
    int                     error_count;

    logic [31:0]            lcg_state;
    logic [`SPI_WORD_W-1:0] resp_word;               // Slave reply for the next frame.
    logic [`SPI_WORD_W-1:0] slave_sr;
    logic [`SPI_WORD_W-1:0] mosi_rec;
    logic                   cs_prev;
    logic                   sclk_prev;

    tb_clkgen u_clkgen (
        .clk (clk),
        .rst (rst)
    );

    spi_capture_top dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .tx_word      (tx_word),
        .busy         (busy),
        .miso         (miso),
        .sclk         (sclk),
        .mosi         (mosi),
        .cs           (cs),
        .rd           (rd),
        .rd_valid     (rd_valid),
        .is_reg       (is_reg),
        .reg_addr     (reg_addr),
        .reg_data     (reg_data),
        .sample_chan  (sample_chan),
        .sample_value (sample_value),
        .rx_late      (rx_late)
    );

    tb_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .cs           (cs),
        .busy         (busy),
        .rd_valid     (rd_valid),
        .is_reg       (is_reg),
        .reg_addr     (reg_addr),
        .reg_data     (reg_data),
        .sample_chan  (sample_chan),
        .sample_value (sample_value),
        .rx_late      (rx_late),
        .mosi_word    (mosi_rec),
        .exp_valid    (exp_valid),
        .exp_tx       (exp_tx),
        .exp_res      (exp_res),
        .test_end     (test_end),
        .test_num     (test_num),
        .all_done     (all_done),
        .error_count  (error_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Reply fields per the chip word layout. Late word is the reply one bit on.
    function automatic logic [47:0] expected_result(input logic [15:0] cmd,
                                                    input logic [15:0] resp);
        return {cmd[15], resp[14:8], resp[7:0], resp[15:12], resp[11:0], resp[14:0], 1'b0};
    endfunction

    // ########################################################################
    // Stimulus
    // ########################################################################

    task automatic make_cmd(input logic rw, output logic [15:0] cmd);
        lcg_state = lcg_next(lcg_state);
        cmd       = {rw, lcg_state[30:16]};
    endtask

    task automatic issue_cmd(input logic [15:0] cmd);
        while (busy) begin
            @(posedge clk);
            #1;
        end
        lcg_state = lcg_next(lcg_state);
        resp_word = lcg_state[31:16];
        start     = 1'b1;
        tx_word   = cmd;
        exp_valid = 1'b1;
        exp_tx    = cmd;
        exp_res   = expected_result(cmd, lcg_state[31:16]);
        @(posedge clk);
        #1;
        start     = 1'b0;
        exp_valid = 1'b0;
    endtask

    // A start that the scheduler must drop.
    task automatic poke_start(input logic [15:0] cmd);
        start   = 1'b1;
        tx_word = cmd;
        @(posedge clk);
        #1;
        start   = 1'b0;
    endtask

    task automatic read_result();
        rd = 1'b1;
        @(posedge clk);
        #1;
        while (!rd_valid) begin
            @(posedge clk);
            #1;
        end
        rd = 1'b0;
    endtask

    task automatic read_while_empty();
        rd = 1'b1;
        @(posedge clk);
        #1;
        rd = 1'b0;
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input logic [7:0] num);
        test_num = num;
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    initial begin
        logic [15:0] cmd;
        start     = 1'b0;
        tx_word   = '0;
        rd        = 1'b0;
        exp_valid = 1'b0;
        exp_tx    = '0;
        exp_res   = '0;
        test_end  = 1'b0;
        test_num  = '0;
        all_done  = 1'b0;
        lcg_state = 32'h2c328c80;
        resp_word = '0;
        @(negedge rst);
        @(posedge clk);
        #1;

        repeat (4) begin                             // Mixed kinds, read at once.
            make_cmd(lcg_state[20], cmd);
            issue_cmd(cmd);
            read_result();
        end
        finish_test(8'd1);

        repeat (2) begin
            make_cmd(1'b1, cmd);
            issue_cmd(cmd);
            read_result();
        end
        finish_test(8'd2);

        repeat (2) begin
            make_cmd(1'b0, cmd);
            issue_cmd(cmd);
            read_result();
        end
        finish_test(8'd3);

        repeat (`CAP_FIFO_DEPTH) begin               // Fill the FIFO.
            make_cmd(lcg_state[20], cmd);
            issue_cmd(cmd);
            poke_start(~cmd);
        end
        repeat (CYCLES_PER_CMD) poke_start(cmd);     // Last frame, then full.
        repeat (`CAP_FIFO_DEPTH) read_result();
        finish_test(8'd4);

        read_while_empty();
        make_cmd(1'b1, cmd);
        issue_cmd(cmd);
        read_result();
        finish_test(8'd5);

        all_done = 1'b1;
        @(posedge clk);
        #1;
        all_done = 1'b0;
        @(posedge clk);
        #1;
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // ########################################################################
    // SPI slave model
    // ########################################################################

    initial begin
        miso      = 1'b0;
        slave_sr  = '0;
        mosi_rec  = '0;
        cs_prev   = 1'b1;
        sclk_prev = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (cs_prev && !cs) begin
                slave_sr = resp_word;                // MSB out as cs falls.
                mosi_rec = '0;
            end else if (sclk_prev && !sclk) begin
                slave_sr = {slave_sr[`SPI_WORD_W-2:0], 1'b0};
            end
            if (!sclk_prev && sclk) begin
                mosi_rec = {mosi_rec[`SPI_WORD_W-2:0], mosi};
            end
            miso      = slave_sr[`SPI_WORD_W-1];
            cs_prev   = cs;
            sclk_prev = sclk;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run stopped: not finished within %0d clock cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f compile.f \
    --Mdir obj_dir -o tb_top_sim || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/tb_top_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "ALL CHECKS PASSED" && echo "simulation ok" \
    || { echo "simulation reported errors"; exit 1; }

// ==== src/capture_fifo.sv ====
`default_nettype none
`include "spi_capture_params.svh"

module capture_fifo #(
    parameter int DEPTH = `CAP_FIFO_DEPTH
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         push,
    input  wire spi_capture_pkg::cap_entry_t wr_entry,
    input  wire                         pop,
    output spi_capture_pkg::cap_entry_t rd_entry,
    output logic                        full,
    output logic                        empty
);

    import spi_capture_pkg::*;

    localparam int AW = $clog2(DEPTH);

    cap_entry_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full     = (count == (AW+1)'(DEPTH));
    assign empty    = (count == '0);
    assign rd_entry = mem[rd_ptr];                   // Head shown ahead of pop.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

endmodule

`default_nettype wire

// ==== src/frame_scheduler.sv ====
`default_nettype none
`include "spi_capture_params.svh"

module frame_scheduler (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             start,
    input  wire spi_capture_pkg::chip_word_u tx_word_in,
    input  wire                             full,
    input  wire                             fd_prd,
    input  wire [`SPI_WORD_W-1:0]           rx_early,
    input  wire [`SPI_WORD_W-1:0]           rx_late,
    output logic                            fs,
    output logic [`SPI_WORD_W-1:0]          tx_word,
    output logic                            busy,
    output logic                            push,
    output spi_capture_pkg::cap_entry_t     push_entry
);

    import spi_capture_pkg::*;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_ARM  = 2'd1;
    localparam logic [1:0] S_RUN  = 2'd2;
    localparam logic [1:0] S_PUSH = 2'd3;

    logic [1:0] state;
    logic       accept;
    chip_word_u cmd_q;

    // A full FIFO blocks new frames, so a push always finds room.
    assign busy   = (state != S_IDLE) || full;
    assign accept = start && !busy;
    assign fs     = (state == S_RUN);
    assign push   = (state == S_PUSH);

    assign tx_word    = cmd_q;
    assign push_entry = '{is_read: cmd_q.regv.rw, early: rx_early, late: rx_late};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (accept) state <= S_ARM;
                S_ARM:   state <= S_RUN;
                S_RUN:   if (fd_prd) state <= S_PUSH;   // Drops fs.
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= tx_word_in;
        end
    end

endmodule

`default_nettype wire

// ==== src/result_reader.sv ====
`default_nettype none
`include "spi_capture_params.svh"

module result_reader (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         rd,
    input  wire                         empty,
    input  wire spi_capture_pkg::cap_entry_t entry,
    output logic                        pop,
    output logic                        rd_valid,
    output logic                        is_reg,
    output logic [6:0]                  reg_addr,
    output logic [7:0]                  reg_data,
    output logic [3:0]                  sample_chan,
    output logic [11:0]                 sample_value,
    output logic [`SPI_WORD_W-1:0]      rx_late
);

    import spi_capture_pkg::*;

    chip_word_u reply;

    assign pop   = rd && !empty;                     // Reads on empty are dropped.
    assign reply = entry.early;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= 1'b0;
            is_reg   <= 1'b0;
        end else begin
            rd_valid <= pop;
            if (pop) begin
                is_reg <= entry.is_read;
            end
        end
    end

    // Only the view chosen by the command is refreshed.
    always_ff @(posedge clk) begin
        if (pop) begin
            rx_late <= entry.late;
            if (entry.is_read) begin
                reg_addr <= reply.regv.addr;
                reg_data <= reply.regv.data;
            end else begin
                sample_chan  <= reply.samp.chan;
                sample_value <= reply.samp.value;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/spi_capture_params.svh ====
`ifndef SPI_CAPTURE_PARAMS_SVH
`define SPI_CAPTURE_PARAMS_SVH

// Converter word width.
`define SPI_WORD_W 16

// Entries in the capture FIFO, a power of two.
`define CAP_FIFO_DEPTH 8

// Idle cycles with cs high before the engine reports done.
`define SPI_GAP_CYCLES 10

`endif

// ==== src/spi_capture_pkg.sv ====
`default_nettype none
`include "spi_capture_params.svh"

package spi_capture_pkg;

    typedef struct packed {
        logic       rw;                      // Set for a register read.
        logic [6:0] addr;
        logic [7:0] data;
    } reg_view_t;

    typedef struct packed {
        logic [3:0]  chan;
        logic [11:0] value;
    } sample_view_t;

    // One chip word, decoded by the rw bit of the command that asked for it.
    typedef union packed {
        reg_view_t    regv;
        sample_view_t samp;
    } chip_word_u;

    typedef struct packed {
        logic                   is_read;
        logic [`SPI_WORD_W-1:0] early;       // Sampled with sclk high.
        logic [`SPI_WORD_W-1:0] late;        // Sampled after sclk falls.
    } cap_entry_t;

endpackage

`default_nettype wire

// ==== src/spi_capture_top.sv ====
`default_nettype none
`include "spi_capture_params.svh"

module spi_capture_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    input  wire [`SPI_WORD_W-1:0]  tx_word,
    output logic                   busy,
    input  wire                    miso,
    output logic                   sclk,
    output logic                   mosi,
    output logic                   cs,
    input  wire                    rd,
    output logic                   rd_valid,
    output logic                   is_reg,
    output logic [6:0]             reg_addr,
    output logic [7:0]             reg_data,
    output logic [3:0]             sample_chan,
    output logic [11:0]            sample_value,
    output logic [`SPI_WORD_W-1:0] rx_late
);

    import spi_capture_pkg::*;

    logic                   fs;
    logic                   fd_prd;
    logic [`SPI_WORD_W-1:0] frame_word;
    logic [`SPI_WORD_W-1:0] cap_early;
    logic [`SPI_WORD_W-1:0] cap_late;
    logic                   push;
    logic                   pop;
    logic                   full;
    logic                   empty;
    cap_entry_t             push_entry;
    cap_entry_t             head_entry;

    frame_scheduler u_sched (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .tx_word_in (tx_word),
        .full       (full),
        .fd_prd     (fd_prd),
        .rx_early   (cap_early),
        .rx_late    (cap_late),
        .fs         (fs),
        .tx_word    (frame_word),
        .busy       (busy),
        .push       (push),
        .push_entry (push_entry)
    );

    spi_frame_engine u_engine (
        .clk      (clk),
        .rst      (rst),
        .fs       (fs),
        .tx_word  (frame_word),
        .miso     (miso),
        .sclk     (sclk),
        .mosi     (mosi),
        .cs       (cs),
        .fd_spi   (),
        .fd_prd   (fd_prd),
        .rx_early (cap_early),
        .rx_late  (cap_late)
    );

    capture_fifo #(
        .DEPTH (`CAP_FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .wr_entry (push_entry),
        .pop      (pop),
        .rd_entry (head_entry),
        .full     (full),
        .empty    (empty)
    );

    result_reader u_reader (
        .clk          (clk),
        .rst          (rst),
        .rd           (rd),
        .empty        (empty),
        .entry        (head_entry),
        .pop          (pop),
        .rd_valid     (rd_valid),
        .is_reg       (is_reg),
        .reg_addr     (reg_addr),
        .reg_data     (reg_data),
        .sample_chan  (sample_chan),
        .sample_value (sample_value),
        .rx_late      (rx_late)
    );

endmodule

`default_nettype wire

// ==== src/spi_frame_engine.sv ====
`default_nettype none
`include "spi_capture_params.svh"

module spi_frame_engine (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    fs,
    input  wire [`SPI_WORD_W-1:0]  tx_word,
    input  wire                    miso,
    output logic                   sclk,
    output logic                   mosi,
    output logic                   cs,
    output logic                   fd_spi,
    output logic                   fd_prd,
    output logic [`SPI_WORD_W-1:0] rx_early,
    output logic [`SPI_WORD_W-1:0] rx_late
);

    localparam logic [2:0] S_WAIT  = 3'd0;
    localparam logic [2:0] S_WORK  = 3'd1;
    localparam logic [2:0] S_SHIFT = 3'd2;
    localparam logic [2:0] S_TAIL  = 3'd3;
    localparam logic [2:0] S_END   = 3'd4;
    localparam logic [2:0] S_GAP   = 3'd5;
    localparam logic [2:0] S_DONE  = 3'd6;

    // Four clk per bit, so sclk runs at clk/4.
    localparam logic [1:0] PH_MOSI = 2'd0;
    localparam logic [1:0] PH_SCLK = 2'd1;
    localparam logic [1:0] PH_HOLD = 2'd2;
    localparam logic [1:0] PH_MISO = 2'd3;

    localparam int BW = $clog2(`SPI_WORD_W);
    localparam int GW = $clog2(`SPI_GAP_CYCLES);
    localparam logic [BW-1:0] LAST_BIT = BW'(`SPI_WORD_W - 1);
    localparam logic [GW-1:0] LAST_GAP = GW'(`SPI_GAP_CYCLES - 1);

    logic [2:0]             state;
    logic [1:0]             phase;
    logic [BW-1:0]          bit_cnt;
    logic [GW-1:0]          gap_cnt;
    logic [`SPI_WORD_W-1:0] early_sr;
    logic [`SPI_WORD_W-1:0] late_sr;

    assign fd_prd = (state == S_DONE);

    // ########################################################################
    // Frame sequencing and pin drive
    // ########################################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_WAIT;
            phase   <= PH_MOSI;
            bit_cnt <= '0;
            gap_cnt <= '0;
            cs      <= 1'b1;
            sclk    <= 1'b0;
            mosi    <= 1'b0;
            fd_spi  <= 1'b0;
        end else begin
            case (state)
                S_WAIT: begin
                    fd_spi <= 1'b0;
                    if (fs) begin
                        state <= S_WORK;
                    end
                end
                S_WORK: begin
                    cs      <= 1'b0;
                    mosi    <= 1'b0;
                    phase   <= PH_MOSI;
                    bit_cnt <= '0;
                    state   <= S_SHIFT;
                end
                S_SHIFT: begin
                    phase <= phase + 2'd1;           // Wraps into the next bit.
                    case (phase)
                        PH_MOSI: mosi <= tx_word[LAST_BIT - bit_cnt];  // MSB first.
                        PH_SCLK: sclk <= 1'b1;
                        PH_MISO: begin
                            sclk <= 1'b0;
                            if (bit_cnt == LAST_BIT) begin
                                state <= S_TAIL;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                        default: ;
                    endcase
                end
                S_TAIL: begin
                    phase <= phase + 2'd1;
                    if (phase == PH_HOLD) begin
                        state <= S_END;
                    end
                end
                S_END: begin
                    cs      <= 1'b1;
                    sclk    <= 1'b0;
                    mosi    <= 1'b0;
                    fd_spi  <= 1'b1;
                    gap_cnt <= '0;
                    state   <= S_GAP;
                end
                S_GAP: begin
                    if (gap_cnt == LAST_GAP) begin
                        state <= S_DONE;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                S_DONE: begin
                    fd_spi <= 1'b0;
                    if (!fs) begin
                        state <= S_WAIT;             // Released by the scheduler.
                    end
                end
                default: state <= S_WAIT;
            endcase
        end
    end

    // ########################################################################
    // MISO capture
    // ########################################################################

    // The late word lags one bit slot, so its last bit falls in the tail.
    always_ff @(posedge clk) begin
        case (state)
            S_SHIFT: begin
                if (phase == PH_MISO) begin
                    early_sr <= {early_sr[`SPI_WORD_W-2:0], miso};
                end
                if (phase == PH_SCLK && bit_cnt != '0) begin
                    late_sr <= {late_sr[`SPI_WORD_W-2:0], miso};
                end
            end
            S_TAIL: begin
                if (phase == PH_SCLK) begin
                    late_sr <= {late_sr[`SPI_WORD_W-2:0], miso};
                end
                if (phase == PH_HOLD) begin
                    rx_early <= early_sr;            // End of capture.
                    rx_late  <= late_sr;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire
